//--- design/cordic_fmt_pkg.sv
// cordic number formats: angle, internal vector and result widths with fixed-point constants
package cordic_fmt_pkg;

    // input angle in radians, signed, 6 fractional bits
    localparam int angle_w = 8;

    // pi/2 * 64 rounded down, largest legal angle magnitude
    localparam int angle_max = 100;

    // internal datapath, signed, 12 fractional bits
    localparam int vec_w = 14;

    // distance between the angle/result format and the internal format
    localparam int frac_shift = 6;

    // result word, signed, same scaling as the angle
    localparam int res_w = 8;

    typedef logic signed [angle_w-1:0] angle_t;
    typedef logic signed [res_w-1:0]   res_t;
    typedef logic signed [vec_w-1:0]   vec_word_t;

    // 1/K for twelve iterations, 0.6072 * 4096
    // starting x with this value means no gain correction after the last stage
    localparam vec_word_t cordic_gain_inv = 14'sd2487;

    // rotating vector plus the angle still left to rotate
    typedef struct packed {
        // cosine after the last stage
        vec_word_t x;
        // sine after the last stage
        vec_word_t y;
        // angle residual, driven toward zero
        vec_word_t z;
    } cordic_vec_t;

endpackage

//--- design/cordic_pipe_pkg.sv
// cordic pipeline structure: stage count, latency, stage word and arctangent table
package cordic_pipe_pkg;

    import cordic_fmt_pkg::*;

    // rotation stages, one shift amount each
    localparam int n_iter = 12;

    // input register, rotation stages, rounding register, output register
    localparam int latency = 1 + n_iter + 2;

    // atan(2^-i) in the internal format, 12 fractional bits
    localparam vec_word_t atan_table [n_iter] = '{
        14'sd3217,
        14'sd1899,
        14'sd1003,
        14'sd509,
        14'sd256,
        14'sd128,
        14'sd64,
        14'sd32,
        14'sd16,
        14'sd8,
        14'sd4,
        14'sd2
    };

    // word moved between all pipeline registers
    // a low valid bit marks a bubble, its other fields carry no meaning
    typedef struct packed {
        logic        valid;
        // sign of the original angle, sine is negated again at the output
        logic        neg;
        cordic_vec_t vec;
    } stage_word_t;

endpackage

//--- design/angle_fold.sv
// angle fold: registers the input, folds it to a positive angle and loads the start vector
`timescale 1ns/1ps

module angle_fold (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         angle_valid,
    input  cordic_fmt_pkg::angle_t       angle,
    output cordic_pipe_pkg::stage_word_t fold_out
);
    import cordic_fmt_pkg::*;

    angle_t      angle_abs;
    vec_word_t   z_start;
    logic        valid_q;
    logic        neg_q;
    cordic_vec_t vec_q;

    // the iterations only cover 0 to pi/2, so fold the angle and remember its sign
    // |angle| <= angle_max, negation never wraps
    always_comb begin
        angle_abs = angle[angle_w-1] ? -angle : angle;
        // sign extend first, then move up to 12 fractional bits
        z_start = vec_word_t'(angle_abs) <<< frac_shift;
    end

    // valid is the only control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= angle_valid;
        end
    end

    // start vector (1/K, 0) so x and y end as plain cosine and sine
    always_ff @(posedge clk) begin
        neg_q   <= angle[angle_w-1];
        vec_q.x <= cordic_gain_inv;
        vec_q.y <= '0;
        vec_q.z <= z_start;
    end

    assign fold_out = '{valid: valid_q, neg: neg_q, vec: vec_q};

endmodule

//--- design/cordic_stage.sv
// cordic stage: one registered rotation iteration with a fixed shift and table entry
`timescale 1ns/1ps

module cordic_stage #(
    // iteration index, picks both the shift and the atan entry
    parameter int unsigned shift = 0
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cordic_pipe_pkg::stage_word_t stage_in,
    output cordic_pipe_pkg::stage_word_t stage_out
);
    import cordic_fmt_pkg::*;
    import cordic_pipe_pkg::*;

    vec_word_t   x_in;
    vec_word_t   y_in;
    vec_word_t   z_in;
    vec_word_t   x_sh;
    vec_word_t   y_sh;
    logic        valid_q;
    logic        neg_q;
    cordic_vec_t vec_q;
    cordic_vec_t vec_nxt;

    always_comb begin
        // local signed copies keep the shifts arithmetic
        x_in = stage_in.vec.x;
        y_in = stage_in.vec.y;
        z_in = stage_in.vec.z;
        x_sh = x_in >>> shift;
        y_sh = y_in >>> shift;
        if (z_in[vec_w-1]) begin
            // residual negative, we overshot, rotate clockwise
            vec_nxt.x = x_in + y_sh;
            vec_nxt.y = y_in - x_sh;
            vec_nxt.z = z_in + atan_table[shift];
        end else begin
            // residual zero or positive, rotate counter-clockwise
            vec_nxt.x = x_in - y_sh;
            vec_nxt.y = y_in + x_sh;
            vec_nxt.z = z_in - atan_table[shift];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    // bubbles are rotated too, their data is simply never looked at
    always_ff @(posedge clk) begin
        neg_q <= stage_in.neg;
        vec_q <= vec_nxt;
    end

    assign stage_out = '{valid: valid_q, neg: neg_q, vec: vec_q};

endmodule

//--- design/rotation_pipe.sv
// rotation pipe: chain of n_iter cordic stages, one word in and one word out per cycle
`timescale 1ns/1ps

module rotation_pipe (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cordic_pipe_pkg::stage_word_t pipe_in,
    output cordic_pipe_pkg::stage_word_t pipe_out
);
    import cordic_pipe_pkg::*;

    // link i feeds stage i, the last link is the pipe output
    stage_word_t link [n_iter+1];

    assign link[0] = pipe_in;

    // stage i shifts by i and uses atan(2^-i)
    // no stall path, every stage advances each cycle
    for (genvar i = 0; i < n_iter; i++) begin : g_stage
        cordic_stage #(
            .shift(i)
        ) stage_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .stage_in (link[i]),
            .stage_out(link[i+1])
        );
    end

    // x holds cosine and y holds sine here, still at internal precision
    assign pipe_out = link[n_iter];

endmodule

//--- design/result_round.sv
// result round: rounds x and y to the result format and restores the sign of the sine
`timescale 1ns/1ps

module result_round (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cordic_pipe_pkg::stage_word_t round_in,
    output logic                         result_valid,
    output cordic_fmt_pkg::res_t         sine,
    output cordic_fmt_pkg::res_t         cosine
);
    import cordic_fmt_pkg::*;

    logic rnd_valid;
    logic rnd_neg;
    res_t rnd_sine;
    res_t rnd_cosine;

    // round half up: keep the top res_w bits, add the first dropped bit
    function automatic res_t round_half_up(vec_word_t v);
        res_t top;
        res_t half;
        top  = res_t'(v[vec_w-1:frac_shift]);
        half = res_t'(v[frac_shift-1]);
        return top + half;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rnd_valid    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            rnd_valid    <= round_in.valid;
            result_valid <= rnd_valid;
        end
    end

    // rounding register
    // both values are >= 0 here since the angle was folded
    always_ff @(posedge clk) begin
        rnd_neg    <= round_in.neg;
        rnd_sine   <= round_half_up(round_in.vec.y);
        rnd_cosine <= round_half_up(round_in.vec.x);
    end

    // output register
    // sine is odd, cosine is even, so only the sine takes the input sign back
    always_ff @(posedge clk) begin
        sine   <= rnd_neg ? -rnd_sine : rnd_sine;
        cosine <= rnd_cosine;
    end

endmodule

//--- design/cordic_sincos.sv
// cordic sin/cos top: fold, twelve rotation stages, rounding, one angle per cycle
`timescale 1ns/1ps

module cordic_sincos (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   angle_valid,
    input  cordic_fmt_pkg::angle_t angle,
    output logic                   result_valid,
    output cordic_fmt_pkg::res_t   sine,
    output cordic_fmt_pkg::res_t   cosine
);
    import cordic_pipe_pkg::*;

    // folded start vector into the rotation chain
    stage_word_t fold_word;
    // rotated vector into the rounding stages
    stage_word_t pipe_word;

    angle_fold angle_fold_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .angle_valid(angle_valid),
        .angle      (angle),
        .fold_out   (fold_word)
    );

    rotation_pipe rotation_pipe_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .pipe_in (fold_word),
        .pipe_out(pipe_word)
    );

    result_round result_round_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .round_in    (pipe_word),
        .result_valid(result_valid),
        .sine        (sine),
        .cosine      (cosine)
    );

endmodule

//--- sim/tb_cordic_sincos.sv
// cordic sin/cos testbench: directed tests against a real-valued sine and cosine model
`timescale 1ns/1ps

module tb_cordic_sincos;

    import cordic_fmt_pkg::*;
    import cordic_pipe_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 3;
    localparam int tol_lsb      = 2;
    localparam int num_random   = 40;
    localparam int num_tests    = 5;
    // zero, positive list, symmetry pairs, random stream
    localparam int num_angles   = 1 + 5 + 10 + num_random;
    // worst case a gap after every random angle, plus a drain per test
    localparam int watchdog_cycles =
        reset_cycles + 2 * num_angles + num_tests * (latency + 20) + 50;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   angle_valid;
    angle_t angle;
    logic   result_valid;
    res_t   sine;
    res_t   cosine;

    int          cycle_cnt = 0;
    int          pos_angles [5] = '{1, 25, 50, 67, 100};

    // what went in, in order, with the cycle it was driven in
    int sent_angle_q [$];
    int sent_cycle_q [$];
    // what came out, with the cycle it was seen in
    int res_sine_q [$];
    int res_cos_q [$];
    int res_cycle_q [$];

    cordic_sincos cordic_sincos_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .angle_valid (angle_valid),
        .angle       (angle),
        .result_valid(result_valid),
        .sine        (sine),
        .cosine      (cosine)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // outputs settle after the rising edge, pick them up at the falling one
    always @(negedge clk) begin
        if (result_valid) begin
            res_sine_q.push_back(int'(sine));
            res_cos_q.push_back(int'(cosine));
            res_cycle_q.push_back(cycle_cnt);
        end
    end

    function automatic int round_to_int(real r);
        if (r >= 0.0) begin
            return $rtoi(r + 0.5);
        end else begin
            return -$rtoi(0.5 - r);
        end
    endfunction

    // angle has 6 fractional bits, so does the result
    function automatic int model_sine(int a);
        return round_to_int($sin($itor(a) / 64.0) * 64.0);
    endfunction

    function automatic int model_cosine(int a);
        return round_to_int($cos($itor(a) / 64.0) * 64.0);
    endfunction

    task automatic check_value(input string name, input int got, input int expected,
                               input int tol);
        int diff;
        diff = got - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tol) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic drive_angle(input int a);
        @(posedge clk);
        #2;
        angle_valid = 1'b1;
        angle       = angle_t'(a);
        sent_angle_q.push_back(a);
        sent_cycle_q.push_back(cycle_cnt);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        angle_valid = 1'b0;
    endtask

    // wait for a given number of results, then a few more cycles to catch extras
    task automatic wait_results(input int expected);
        int waited;
        waited = 0;
        while (res_sine_q.size() < expected && waited < latency + 20) begin
            @(posedge clk);
            waited++;
        end
        if (res_sine_q.size() < expected) begin
            $display("ERRORS FOUND");
            $fatal(1, "timed out waiting for %0d results, got %0d", expected,
                   res_sine_q.size());
        end
        repeat (4) @(posedge clk);
        check_value("result_count", res_sine_q.size(), expected, 0);
    endtask

    // pop every sent angle with its result, check value and arrival cycle
    task automatic check_against_model(input int tol);
        int a;
        int c;
        while (sent_angle_q.size() > 0) begin
            a = sent_angle_q.pop_front();
            c = sent_cycle_q.pop_front();
            check_value("sine", res_sine_q.pop_front(), model_sine(a), tol);
            check_value("cosine", res_cos_q.pop_front(), model_cosine(a), tol);
            check_value("result_cycle", res_cycle_q.pop_front(), c + latency, 0);
        end
    endtask

    // nothing driven, nothing may come out
    task automatic idle_after_reset();
        repeat (latency) @(posedge clk);
        check_value("result_count", res_sine_q.size(), 0, 0);
    endtask

    task automatic zero_angle();
        drive_angle(0);
        drive_idle();
        wait_results(1);
        void'(sent_angle_q.pop_front());
        check_value("result_cycle", res_cycle_q.pop_front(),
                    sent_cycle_q.pop_front() + latency, 0);
        check_value("sine", res_sine_q.pop_front(), 0, 1);
        check_value("cosine", res_cos_q.pop_front(), 64, tol_lsb);
    endtask

    task automatic positive_angles();
        foreach (pos_angles[i]) begin
            drive_angle(pos_angles[i]);
        end
        drive_idle();
        wait_results(5);
        check_against_model(tol_lsb);
    endtask

    // a and -a back to back, sine must flip sign exactly and cosine match
    task automatic sign_symmetry();
        int pos_s;
        int pos_c;
        foreach (pos_angles[i]) begin
            drive_angle(pos_angles[i]);
            drive_angle(-pos_angles[i]);
        end
        drive_idle();
        wait_results(10);
        while (sent_angle_q.size() > 0) begin
            void'(sent_angle_q.pop_front());
            void'(sent_angle_q.pop_front());
            check_value("result_cycle", res_cycle_q.pop_front(),
                        sent_cycle_q.pop_front() + latency, 0);
            check_value("result_cycle", res_cycle_q.pop_front(),
                        sent_cycle_q.pop_front() + latency, 0);
            pos_s = res_sine_q.pop_front();
            pos_c = res_cos_q.pop_front();
            check_value("sine_neg", res_sine_q.pop_front(), -pos_s, 0);
            check_value("cosine_neg", res_cos_q.pop_front(), pos_c, 0);
        end
    endtask

    // random angles with random single idle cycles between them
    task automatic random_stream();
        for (int i = 0; i < num_random; i++) begin
            drive_angle(int'($urandom_range(2 * angle_max)) - angle_max);
            if ($urandom_range(1) == 1) begin
                drive_idle();
            end
        end
        drive_idle();
        wait_results(num_random);
        check_against_model(tol_lsb);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired, the tests did not finish in time");
    end

    initial begin
        arst_n      = 1'b0;
        angle_valid = 1'b0;
        angle       = '0;
        void'($urandom(51));
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;

        idle_after_reset();
        zero_angle();
        positive_angles();
        sign_symmetry();
        random_stream();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- filelist.f
design/cordic_fmt_pkg.sv
design/cordic_pipe_pkg.sv
design/angle_fold.sv
design/cordic_stage.sv
design/rotation_pipe.sv
design/result_round.sv
design/cordic_sincos.sv
sim/tb_cordic_sincos.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_cordic_sincos -f filelist.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
